//--- project.f
+incdir+hdl
hdl/flow_types_pkg.sv
hdl/flow_ctrl_pkg.sv
hdl/flow_ingress_framer.sv
hdl/flow_flit_fifo.sv
hdl/flow_serializer.sv
hdl/flow_serdes_top.sv
verif/flow_serdes_tb.sv

//--- Makefile
# Verilator flow for the flow serdes link
# Override from the command line, for example: make sim LOG=run2.log

VERILATOR ?= verilator
TOP       ?= flow_serdes_tb
LOG       ?= sim.log
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
		if grep -q "Result: FAILED" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/flow_serdes_tb.sv
// Testbench for the flow serdes link
// Pushes a table of framed 32-bit words, predicts the 8-bit pop flits
// from the slicing rules and checks them under random pop back-pressure

`timescale 1ns/1ps

`include "flow_defs.svh"

module flow_serdes_tb;

  import flow_types_pkg::*;
  import flow_ctrl_pkg::*;

  localparam int n_entries  = 20;
  localparam int n_tests    = 6;
  localparam int wait_limit = 400;
  // Test 0 checks the reset state and test 5 runs with heavy back-pressure
  localparam int t_bp       = 5;

  logic       clk;
  logic       arst_n;
  logic       in_valid;
  push_word_t in_data;
  logic       in_last;
  slice_idx_t in_tail_count;
  logic       in_ready;
  logic       pop_ready;
  logic       pop_valid;
  pop_slice_t pop_data;
  logic       pop_last;
  pkt_id_t    pop_pkt_id;

  // Stimulus table with one push word per row and its expected packet ID
  int         tbl_test [n_entries];
  push_word_t tbl_data [n_entries];
  logic       tbl_last [n_entries];
  slice_idx_t tbl_tail [n_entries];
  pkt_id_t    tbl_id   [n_entries];
  string      test_name [n_tests];

  // Scoreboard of flits still to come with the oldest at the front
  pop_slice_t exp_data [$];
  logic       exp_last [$];
  pkt_id_t    exp_id   [$];

  integer seed        = 32'h8ed0;
  int     ready_level = 3;
  int     errors      = 0;
  int     flits       = 0;
  bit     timed_out   = 1'b0;
  bit     stall_seen  = 1'b0;

  flow_serdes_top uut (
    .clk           (clk),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .in_last       (in_last),
    .in_tail_count (in_tail_count),
    .in_ready      (in_ready),
    .pop_ready     (pop_ready),
    .pop_valid     (pop_valid),
    .pop_data      (pop_data),
    .pop_last      (pop_last),
    .pop_pkt_id    (pop_pkt_id)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Pop side is ready on about ready_level quarters of the cycles
  initial begin
    int level;
    pop_ready = 1'b0;
    forever begin
      @(posedge clk);
      level = ready_level;
      #1;
      pop_ready = (($random(seed) & 3) < level);
    end
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_slice(input string name, input pop_slice_t exp, input pop_slice_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_pkt_id(input string name, input pkt_id_t exp, input pkt_id_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  // Compares any single-bit result such as pop_last or a handshake bit
  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------

  task automatic set_entry(input int idx, input int test, input push_word_t data,
                           input logic last, input slice_idx_t tail, input pkt_id_t id);
    tbl_test[idx] = test;
    tbl_data[idx] = data;
    tbl_last[idx] = last;
    tbl_tail[idx] = tail;
    tbl_id[idx]   = id;
  endtask

  // Tail count is ignored on non-last words, so those rows carry 0
  task automatic load_table();
    test_name[0] = "reset state";
    test_name[1] = "slice order";
    test_name[2] = "tail drop";
    test_name[3] = "single-slice packet";
    test_name[4] = "packet IDs";
    test_name[5] = "back-pressure";
    set_entry(0,  1, 32'hBAADF00D, 1'b0, 2'd0, 3'd0);
    set_entry(1,  1, 32'h12345678, 1'b1, 2'd3, 3'd0);
    set_entry(2,  2, 32'hA1B2C3D4, 1'b0, 2'd0, 3'd1);
    set_entry(3,  2, 32'hCAFEBEEF, 1'b1, 2'd1, 3'd1);
    set_entry(4,  3, 32'h5AC3E1F0, 1'b1, 2'd0, 3'd2);
    // Packet IDs run 3 to 7 and then wrap to 0 and 1
    set_entry(5,  4, 32'h0F1E2D3C, 1'b1, 2'd2, 3'd3);
    set_entry(6,  4, 32'h44556677, 1'b0, 2'd0, 3'd4);
    set_entry(7,  4, 32'h8899AABB, 1'b1, 2'd0, 3'd4);
    set_entry(8,  4, 32'hC0FFEE00, 1'b1, 2'd3, 3'd5);
    set_entry(9,  4, 32'hDEADBEEF, 1'b1, 2'd1, 3'd6);
    set_entry(10, 4, 32'h13579BDF, 1'b1, 2'd2, 3'd7);
    set_entry(11, 4, 32'h2468ACE0, 1'b1, 2'd0, 3'd0);
    set_entry(12, 4, 32'hFEDCBA98, 1'b1, 2'd3, 3'd1);
    set_entry(13, 5, 32'h01234567, 1'b0, 2'd0, 3'd2);
    set_entry(14, 5, 32'h89ABCDEF, 1'b0, 2'd0, 3'd2);
    set_entry(15, 5, 32'h0BADCAFE, 1'b1, 2'd3, 3'd2);
    set_entry(16, 5, 32'h11223344, 1'b0, 2'd0, 3'd3);
    set_entry(17, 5, 32'h55667788, 1'b1, 2'd2, 3'd3);
    set_entry(18, 5, 32'hDDEEFF00, 1'b0, 2'd0, 3'd4);
    set_entry(19, 5, 32'hA5A5C3C3, 1'b1, 2'd1, 3'd4);
  endtask

  // A last word keeps tail+1 slices and any other word keeps all of them
  // The most significant slice always leaves first
  task automatic queue_expected(input int idx);
    int n;
    int k;
    int sel;
    n = tbl_last[idx] ? int'(tbl_tail[idx]) + 1 : `FLOW_SER_RATIO;
    for (k = 0; k < n; k++) begin
      sel = `FLOW_SER_RATIO - 1 - k;
      exp_data.push_back(tbl_data[idx][sel*`FLOW_POP_WIDTH +: `FLOW_POP_WIDTH]);
      exp_last.push_back(tbl_last[idx] && (k == n - 1));
      exp_id.push_back(tbl_id[idx]);
    end
  endtask

  // ----------------------------------------
  // Driver and drain
  // ----------------------------------------

  // Holds the word until in_ready is seen high ahead of a rising edge
  task automatic push_word(input int idx);
    int waited;
    bit taken;
    waited        = 0;
    taken         = 1'b0;
    in_valid      = 1'b1;
    in_data       = tbl_data[idx];
    in_last       = tbl_last[idx];
    in_tail_count = tbl_tail[idx];
    while (!taken && waited < wait_limit) begin
      @(negedge clk);
      if (in_ready) begin
        taken = 1'b1;
      end else begin
        stall_seen = 1'b1;
      end
      @(posedge clk);
      #1;
      waited++;
    end
    in_valid = 1'b0;
    if (!taken) begin
      $display("Timeout: table row %0d was never accepted by the link", idx);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_data.size() != 0 && waited < wait_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_data.size() != 0) begin
      $display("Timeout: %0d expected pop flits never came out", exp_data.size());
      errors++;
      timed_out = 1'b1;
    end else begin
      // Final flit is gone by now, so nothing may be left on the pop side
      repeat (2) @(negedge clk);
      check_flag("pop_valid", 1'b0, pop_valid);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input int t, input int first_err);
    if (errors == first_err) begin
      $display("Test %0d %s: ok", t, test_name[t]);
    end else begin
      $display("Test %0d %s: %0d errors", t, test_name[t], errors - first_err);
    end
  endtask

  // Flits are taken at the negative edge ahead of the transfer edge
  initial begin : monitor
    pop_slice_t want_data;
    logic       want_last;
    pkt_id_t    want_id;
    forever begin
      @(negedge clk);
      if (arst_n && pop_valid && pop_ready) begin
        if (exp_data.size() == 0) begin
          $display("Unexpected pop flit %h at %0t with none expected", pop_data, $time);
          errors++;
        end else begin
          want_data = exp_data.pop_front();
          want_last = exp_last.pop_front();
          want_id   = exp_id.pop_front();
          check_slice("pop_data", want_data, pop_data);
          check_flag("pop_last", want_last, pop_last);
          check_pkt_id("pop_pkt_id", want_id, pop_pkt_id);
          flits++;
        end
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin : main
    int first_err;
    int t;
    int i;
    arst_n        = 1'b0;
    in_valid      = 1'b0;
    in_data       = '0;
    in_last       = 1'b0;
    in_tail_count = '0;
    load_table();
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    first_err = errors;
    @(negedge clk);
    check_flag("pop_valid", 1'b0, pop_valid);
    check_flag("in_ready", 1'b1, in_ready);
    report_test(0, first_err);
    @(posedge clk);
    #1;
    for (t = 1; t < n_tests && !timed_out; t++) begin
      first_err   = errors;
      ready_level = (t == t_bp) ? 1 : 3;
      stall_seen  = 1'b0;
      for (i = 0; i < n_entries && !timed_out; i++) begin
        if (tbl_test[i] == t) begin
          queue_expected(i);
          push_word(i);
        end
      end
      if (!timed_out) begin
        wait_drained();
      end
      // A full FIFO behind a busy framer must push back on the driver
      if (t == t_bp && !stall_seen) begin
        $display("in_ready never went low while the FIFO was filling");
        errors++;
      end
      report_test(t, first_err);
    end
    $display("Tests run: %0d, flits checked: %0d, errors: %0d", t, flits, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : flow_serdes_tb

//--- hdl/flow_serdes_top.sv
// Flow serdes link top level
// Framer, flit FIFO and serializer in a row, 32-bit words in and
// 8-bit flits out with ready/valid on both ends

`timescale 1ns/1ps

`include "flow_defs.svh"

module flow_serdes_top (
  input  logic                       clk,
  input  logic                       arst_n,
  // Wide push side
  input  logic                       in_valid,
  input  flow_types_pkg::push_word_t in_data,
  input  logic                       in_last,
  input  flow_ctrl_pkg::slice_idx_t  in_tail_count,
  output logic                       in_ready,
  // Narrow pop side
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output flow_types_pkg::pop_slice_t pop_data,
  output logic                       pop_last,
  output flow_ctrl_pkg::pkt_id_t     pop_pkt_id
);

  import flow_types_pkg::*;
  import flow_ctrl_pkg::*;

  // ----------------------------------------
  // Framer to FIFO
  // ----------------------------------------
  logic       fr_valid;
  logic       fr_ready;
  push_word_t fr_data;
  logic       fr_last;
  slice_idx_t fr_dont_care;
  pkt_id_t    fr_pkt_id;

  // ----------------------------------------
  // FIFO to serializer
  // ----------------------------------------
  logic       q_valid;
  logic       q_ready;
  push_word_t q_data;
  logic       q_last;
  slice_idx_t q_dont_care;
  pkt_id_t    q_pkt_id;

  // Register stage that frames and tags the incoming words
  flow_ingress_framer u_framer (
    .clk           (clk),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .in_last       (in_last),
    .in_tail_count (in_tail_count),
    .in_ready      (in_ready),
    .fr_ready      (fr_ready),
    .fr_valid      (fr_valid),
    .fr_data       (fr_data),
    .fr_last       (fr_last),
    .fr_dont_care  (fr_dont_care),
    .fr_pkt_id     (fr_pkt_id)
  );

  // Decoupling buffer, absorbs pop side back-pressure
  flow_flit_fifo u_fifo (
    .clk          (clk),
    .arst_n       (arst_n),
    .fr_valid     (fr_valid),
    .fr_data      (fr_data),
    .fr_last      (fr_last),
    .fr_dont_care (fr_dont_care),
    .fr_pkt_id    (fr_pkt_id),
    .fr_ready     (fr_ready),
    .q_ready      (q_ready),
    .q_valid      (q_valid),
    .q_data       (q_data),
    .q_last       (q_last),
    .q_dont_care  (q_dont_care),
    .q_pkt_id     (q_pkt_id)
  );

  // Width conversion from the FIFO head to narrow flits
  flow_serializer u_serializer (
    .clk         (clk),
    .arst_n      (arst_n),
    .q_valid     (q_valid),
    .q_data      (q_data),
    .q_last      (q_last),
    .q_dont_care (q_dont_care),
    .q_pkt_id    (q_pkt_id),
    .q_ready     (q_ready),
    .pop_ready   (pop_ready),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_last    (pop_last),
    .pop_pkt_id  (pop_pkt_id)
  );

endmodule : flow_serdes_top

//--- hdl/flow_serializer.sv
// Flow serializer
// Cuts the FIFO head word into narrow pop flits through a slice mux,
// drops the don't-care tail of last words and repeats the packet ID
// on every flit

`timescale 1ns/1ps

`include "flow_defs.svh"

module flow_serializer (
  input  logic                       clk,
  input  logic                       arst_n,
  // Head of the flit FIFO
  input  logic                       q_valid,
  input  flow_types_pkg::push_word_t q_data,
  input  logic                       q_last,
  input  flow_ctrl_pkg::slice_idx_t  q_dont_care,
  input  flow_ctrl_pkg::pkt_id_t     q_pkt_id,
  output logic                       q_ready,
  // Narrow pop side to the outside
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output flow_types_pkg::pop_slice_t pop_data,
  output logic                       pop_last,
  output flow_ctrl_pkg::pkt_id_t     pop_pkt_id
);

  import flow_types_pkg::*;
  import flow_ctrl_pkg::*;

  localparam slice_idx_t last_slice = slice_idx_t'(`FLOW_SER_RATIO - 1);
  localparam bit         msb_first  = `FLOW_MSB_FIRST;

  slice_idx_t slice_cnt;
  slice_idx_t slice_sel;
  slice_idx_t cnt_plus_dc;
  logic       final_slice;
  logic       pop_accept;
  pop_slice_t slices [`FLOW_SER_RATIO];

  // ----------------------------------------
  // Slice mux
  // ----------------------------------------

  // Split the head word into its slices, slice 0 holds the low bits
  for (genvar i = 0; i < `FLOW_SER_RATIO; i++) begin : gen_slice
    assign slices[i] = q_data[i*`FLOW_POP_WIDTH +: `FLOW_POP_WIDTH];
  end

  // With MSB first the counter walks the slices from the top down
  assign slice_sel = msb_first ? (last_slice - slice_cnt) : slice_cnt;
  assign pop_data  = slices[slice_sel];

  // ----------------------------------------
  // Pop side outputs
  // ----------------------------------------

  // Zero latency, a valid head word is a valid pop flit
  assign pop_valid  = q_valid;
  assign pop_pkt_id = q_pkt_id;

  // The word ends early by its don't-care count
  // For a non-last word the count is zero and this hits at the top slice
  assign cnt_plus_dc = slice_cnt + q_dont_care;
  assign final_slice = (cnt_plus_dc == last_slice);
  assign pop_last    = q_last && final_slice;
  assign pop_accept  = pop_valid && pop_ready;

  // Release the head entry as its final slice leaves
  assign q_ready = pop_accept && final_slice;

  // ----------------------------------------
  // Slice counter
  // ----------------------------------------

  // Back to zero after the last flit of a packet
  // After a whole non-last word the counter simply wraps
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slice_cnt <= '0;
    end else if (pop_accept) begin
      if (pop_last) begin
        slice_cnt <= '0;
      end else begin
        slice_cnt <= slice_cnt + slice_idx_t'(1);
      end
    end
  end

endmodule : flow_serializer

//--- hdl/flow_flit_fifo.sv
// Flit FIFO
// Holds framed push words between the framer and the serializer, with
// ready/valid on both sides and the head entry driven straight out

`timescale 1ns/1ps

`include "flow_defs.svh"

module flow_flit_fifo (
  input  logic                       clk,
  input  logic                       arst_n,
  // Write side from the framer
  input  logic                       fr_valid,
  input  flow_types_pkg::push_word_t fr_data,
  input  logic                       fr_last,
  input  flow_ctrl_pkg::slice_idx_t  fr_dont_care,
  input  flow_ctrl_pkg::pkt_id_t     fr_pkt_id,
  output logic                       fr_ready,
  // Read side towards the serializer
  input  logic                       q_ready,
  output logic                       q_valid,
  output flow_types_pkg::push_word_t q_data,
  output logic                       q_last,
  output flow_ctrl_pkg::slice_idx_t  q_dont_care,
  output flow_ctrl_pkg::pkt_id_t     q_pkt_id
);

  import flow_types_pkg::*;
  import flow_ctrl_pkg::*;

  // The occupancy needs one bit more than a pointer to tell full from empty
  localparam int cnt_w = `FLOW_FIFO_PTR_WIDTH + 1;

  // Storage, one array per field of a framed word
  push_word_t mem_data      [`FLOW_FIFO_DEPTH];
  logic       mem_last      [`FLOW_FIFO_DEPTH];
  slice_idx_t mem_dont_care [`FLOW_FIFO_DEPTH];
  pkt_id_t    mem_pkt_id    [`FLOW_FIFO_DEPTH];

  fifo_ptr_t        wr_ptr;
  fifo_ptr_t        rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             empty;
  logic             wr_en;
  logic             rd_en;

  // ----------------------------------------
  // Flags and handshakes
  // ----------------------------------------

  assign full     = (count == cnt_w'(`FLOW_FIFO_DEPTH));
  assign empty    = (count == '0);
  assign fr_ready = !full;
  assign q_valid  = !empty;

  // A write and a read can land in the same cycle
  assign wr_en = fr_valid && fr_ready;
  assign rd_en = q_valid && q_ready;

  // Head entry goes out directly, no output register
  assign q_data      = mem_data[rd_ptr];
  assign q_last      = mem_last[rd_ptr];
  assign q_dont_care = mem_dont_care[rd_ptr];
  assign q_pkt_id    = mem_pkt_id[rd_ptr];

  // ----------------------------------------
  // Storage write
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_data[wr_ptr]      <= fr_data;
      mem_last[wr_ptr]      <= fr_last;
      mem_dont_care[wr_ptr] <= fr_dont_care;
      mem_pkt_id[wr_ptr]    <= fr_pkt_id;
    end
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + fifo_ptr_t'(1);
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + fifo_ptr_t'(1);
      end
      // Count only moves when exactly one side is active
      case ({wr_en, rd_en})
        2'b10:   count <= count + cnt_w'(1);
        2'b01:   count <= count - cnt_w'(1);
        default: count <= count;
      endcase
    end
  end

endmodule : flow_flit_fifo

//--- hdl/flow_ingress_framer.sv
// Ingress framer
// Registers accepted push words, converts the tail count of a last word
// into a don't-care count and tags every word with a packet ID

`timescale 1ns/1ps

`include "flow_defs.svh"

module flow_ingress_framer (
  input  logic                       clk,
  input  logic                       arst_n,
  // Push side from the outside
  input  logic                       in_valid,
  input  flow_types_pkg::push_word_t in_data,
  input  logic                       in_last,
  input  flow_ctrl_pkg::slice_idx_t  in_tail_count,
  output logic                       in_ready,
  // Framed words towards the flit FIFO
  input  logic                       fr_ready,
  output logic                       fr_valid,
  output flow_types_pkg::push_word_t fr_data,
  output logic                       fr_last,
  output flow_ctrl_pkg::slice_idx_t  fr_dont_care,
  output flow_ctrl_pkg::pkt_id_t     fr_pkt_id
);

  import flow_ctrl_pkg::*;

  // Highest slice index, the ratio minus one
  localparam slice_idx_t last_slice = slice_idx_t'(`FLOW_SER_RATIO - 1);

  logic       in_accept;
  slice_idx_t dont_care_next;
  pkt_id_t    pkt_id_q;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // The stage takes a new word when it is empty or drains this cycle
  // This keeps one word per cycle when the FIFO has room
  assign in_ready  = !fr_valid || fr_ready;
  assign in_accept = in_valid && in_ready;

  // ----------------------------------------
  // Don't-care count
  // ----------------------------------------

  // Tail count is used slices minus one, so the unused tail is ratio-1-tail
  // A non-last word is always sent whole
  assign dont_care_next = in_last ? (last_slice - in_tail_count) : '0;

  // ----------------------------------------
  // Pipeline register
  // ----------------------------------------

  // Valid bit of the single register stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fr_valid <= 1'b0;
    end else if (in_accept) begin
      fr_valid <= 1'b1;
    end else if (fr_ready) begin
      fr_valid <= 1'b0;
    end
  end

  // Payload only loads on an accepted word
  always_ff @(posedge clk) begin
    if (in_accept) begin
      fr_data      <= in_data;
      fr_last      <= in_last;
      fr_dont_care <= dont_care_next;
      fr_pkt_id    <= pkt_id_q;
    end
  end

  // ----------------------------------------
  // Packet ID counter
  // ----------------------------------------

  // Moves to the next tag once the last word of a packet is taken
  // Wraps around after the highest tag value
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pkt_id_q <= '0;
    end else if (in_accept && in_last) begin
      pkt_id_q <= pkt_id_q + pkt_id_t'(1);
    end
  end

endmodule : flow_ingress_framer

//--- hdl/flow_ctrl_pkg.sv
// Flow link control types
// Slice indices, packet tags and FIFO pointers

`include "flow_defs.svh"

package flow_ctrl_pkg;

  // Slice position inside a push word, also used as a slice count
  // (tail count and don't-care count both fit in it)
  typedef logic [`FLOW_SLICE_IDX_WIDTH-1:0] slice_idx_t;

  // Packet tag carried on every flit of a packet
  typedef logic [`FLOW_PKT_ID_WIDTH-1:0] pkt_id_t;

  // Read and write pointer of the flit FIFO
  // The depth is a power of two so the pointers wrap on their own
  typedef logic [`FLOW_FIFO_PTR_WIDTH-1:0] fifo_ptr_t;

endpackage : flow_ctrl_pkg

//--- hdl/flow_types_pkg.sv
// Flow link data types
// Payload vectors for the wide push side and the narrow pop side

`include "flow_defs.svh"

package flow_types_pkg;

  // ----------------------------------------
  // Push side
  // ----------------------------------------

  // One wide flit as presented by the ingress driver
  // Its slices go out on the pop side in FLOW_MSB_FIRST order
  typedef logic [`FLOW_PUSH_WIDTH-1:0] push_word_t;

  // ----------------------------------------
  // Pop side
  // ----------------------------------------

  // One narrow flit, exactly one slice of a push word
  // The bit order inside a slice is the same as in the push word
  typedef logic [`FLOW_POP_WIDTH-1:0] pop_slice_t;

endpackage : flow_types_pkg

//--- hdl/flow_defs.svh
// Flow link parameters
// Widths, serialization ratio, FIFO depth and slice order shared by the
// framer, the flit FIFO and the serializer
`ifndef FLOW_DEFS_SVH
`define FLOW_DEFS_SVH

// Wide push word and narrow pop flit widths
`define FLOW_PUSH_WIDTH 32
`define FLOW_POP_WIDTH 8

// Number of pop flits carved out of one push word
`define FLOW_SER_RATIO 4
`define FLOW_SLICE_IDX_WIDTH 2

// Packet tag width, wraps after 2**width packets
`define FLOW_PKT_ID_WIDTH 3

// Flit FIFO between framer and serializer
`define FLOW_FIFO_DEPTH 4
`define FLOW_FIFO_PTR_WIDTH 2

// Set to 1 so the most significant slice leaves first
`define FLOW_MSB_FIRST 1

`endif
